// ==== hdl/wallace_mult_config.svh ====
`ifndef WALLACE_MULT_CONFIG_SVH
`define WALLACE_MULT_CONFIG_SVH

// Widths of the unsigned multiplier datapath.

// Bits per operand.
`define MULT_WIDTH 16

// The full product of two operands needs twice the operand width.
`define PROD_WIDTH (2 * `MULT_WIDTH)

// Rising edges from operand capture to the product appearing on the output.
// The operand register samples the inputs, and the carry-save register and
// the product register each add one edge after that.
`define MULT_LATENCY 2

`endif

// ==== hdl/wallace_mult_pkg.sv ====
`include "wallace_mult_config.svh"

package wallace_mult_pkg;

	// One unsigned multiplier input.
	typedef logic [`MULT_WIDTH-1:0] operand_t;

	// Full width unsigned product.
	typedef logic [`PROD_WIDTH-1:0] product_t;

	// Multiplicand and multiplier, presented together every cycle.
	typedef struct packed {
		operand_t a; // Multiplicand.
		operand_t b; // Multiplier.
	} operands_t;

	// Redundant result of the tree.
	// The product is sum + carry, and the carry word is already shifted to its weight.
	typedef struct packed {
		product_t sum;
		product_t carry;
	} carry_save_t;

	// One partial product row, placed at its final bit weight.
	typedef logic [`PROD_WIDTH-1:0] pp_row_t;

endpackage

// ==== hdl/wallace_tree.sv ====
`timescale 1ns/100ps

`include "wallace_mult_config.svh"

// Partial product generation and carry-save reduction.
// Purely combinational. The sixteen rows shrink 16, 11, 8, 6, 4, 3, 2 over six layers.
module wallace_tree (
	input  wallace_mult_pkg::operands_t   operands,
	output wallace_mult_pkg::carry_save_t reduced
);

	import wallace_mult_pkg::*;

	// One partial product row per multiplier bit.
	localparam int ROWS = `MULT_WIDTH;

	// Rows left after one layer of 3:2 compression.
	// Each full group of three gives a sum and a carry row, and leftovers pass through.
	function automatic int rows_after(input int n);
		return 2 * (n / 3) + n % 3;
	endfunction

	// Number of rows entering a given layer.
	function automatic int rows_at(input int layer);
		int n;
		n = ROWS;
		for (int i = 0; i < layer; i++) begin
			n = rows_after(n);
		end
		return n;
	endfunction

	// Layers needed until only a sum and carry row remain.
	function automatic int layer_count();
		int n;
		int layers;
		n = ROWS;
		layers = 0;
		while (n > 2) begin
			n = rows_after(n);
			layers++;
		end
		return layers;
	endfunction

	localparam int LAYERS = layer_count(); // Six for sixteen rows.

	// Row storage for every layer.
	// Index 0 holds the raw partial products and index LAYERS the final pair.
	// Slots above the live row count of a layer are tied to zero.
	pp_row_t row [0:LAYERS][0:ROWS-1];

	// Partial products.
	// The multiplicand is gated by one multiplier bit and shifted to that bit's weight.
	for (genvar r = 0; r < ROWS; r++) begin : g_pp
		assign row[0][r] = pp_row_t'(operands.a & {`MULT_WIDTH{operands.b[r]}}) << r;
	end

	// Reduction layers.
	for (genvar l = 0; l < LAYERS; l++) begin : g_layer
		localparam int N_IN   = rows_at(l);
		localparam int GROUPS = N_IN / 3;
		localparam int N_OUT  = rows_after(N_IN);

		// Carry-save adders, one per group of three rows.
		// Every bit column gets its own full adder, with no carry between columns.
		for (genvar g = 0; g < GROUPS; g++) begin : g_csa
			pp_row_t x;
			pp_row_t y;
			pp_row_t z;

			assign x = row[l][3*g];
			assign y = row[l][3*g+1];
			assign z = row[l][3*g+2];

			// Sum stays at the same weight.
			assign row[l+1][2*g] = x ^ y ^ z;

			// Majority moves one place up.
			// The top bit shifted out is always zero since every row is below 2**PROD_WIDTH.
			assign row[l+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
		end

		// One or two leftover rows go to the next layer unchanged.
		// They land right after the 2*GROUPS rows from the adders.
		for (genvar r = 3 * GROUPS; r < N_IN; r++) begin : g_pass
			assign row[l+1][r - GROUPS] = row[l][r];
		end

		// Slots no longer in use from here on.
		for (genvar r = N_OUT; r < ROWS; r++) begin : g_idle
			assign row[l+1][r] = '0;
		end
	end

	// The last layer holds exactly two rows.
	assign reduced.sum   = row[LAYERS][0];
	assign reduced.carry = row[LAYERS][1]; // Already at its weight.

endmodule

// ==== hdl/carry_ripple_adder.sv ====
`timescale 1ns/100ps

`include "wallace_mult_config.svh"

// Final adder of the multiplier.
// Resolves the carry-save pair into one word with a plain ripple chain.
module carry_ripple_adder (
	input  wallace_mult_pkg::carry_save_t operands,
	output wallace_mult_pkg::product_t    sum
);

	import wallace_mult_pkg::*;

	// Carry into each bit position.
	logic [`PROD_WIDTH-1:0] carry;

	assign carry[0] = 1'b0; // Nothing enters the LSB.

	// One full adder cell per bit, LSB first.
	for (genvar i = 0; i < `PROD_WIDTH; i++) begin : g_cell
		logic a;
		logic b;

		assign a = operands.sum[i];
		assign b = operands.carry[i];

		assign sum[i] = a ^ b ^ carry[i];

		// The MSB cell produces no carry out.
		// The product of two unsigned operands always fits in the full width.
		if (i < `PROD_WIDTH - 1) begin : g_carry
			assign carry[i+1] = (a & b) | (a & carry[i]) | (b & carry[i]);
		end
	end

endmodule

// ==== hdl/wallace_mult.sv ====
`timescale 1ns/100ps

// Pipelined unsigned Wallace tree multiplier.
// Operands are accepted on every rising edge with no handshake.
// Stage 1 registers the operands, stage 2 the carry-save pair from the tree,
// and stage 3 the resolved product.
module wallace_mult (
	input  logic                        clk,
	input  logic                        arst_n,
	input  wallace_mult_pkg::operands_t operands,
	output wallace_mult_pkg::product_t  product
);

	import wallace_mult_pkg::*;

	operands_t   operands_q; // Operand register.
	carry_save_t reduced;    // Tree output.
	carry_save_t reduced_q;  // Carry-save register.
	product_t    product_d;  // Ripple adder output.

	// Stage 1.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operands_q <= '0;
		end else begin
			operands_q <= operands;
		end
	end

	// Partial products and 3:2 reduction, combinational.
	wallace_tree u_wallace_tree (
		.operands (operands_q),
		.reduced  (reduced)
	);

	// Stage 2.
	// Splits the tree from the ripple chain, the two long paths of the datapath.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reduced_q <= '0;
		end else begin
			reduced_q <= reduced;
		end
	end

	// Final carry propagation, combinational.
	carry_ripple_adder u_carry_ripple_adder (
		.operands (reduced_q),
		.sum      (product_d)
	);

	// Stage 3.
	// Drives the output straight from a flop.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			product <= '0; // Reads zero during reset.
		end else begin
			product <= product_d;
		end
	end

endmodule

// ==== bench/wallace_mult_properties.sv ====
`timescale 1ns/100ps

`include "wallace_mult_config.svh"

// Assertions on the multiplier top level.
module wallace_mult_properties (
	input logic                        clk,
	input logic                        arst_n,
	input wallace_mult_pkg::operands_t operands_q,
	input wallace_mult_pkg::product_t  product
);

	import wallace_mult_pkg::*;

	// Output stays clear for the whole reset.
	assert_reset_clear: assert property (@(posedge clk) !arst_n |-> product == '0)
		else $error("product is not zero during reset");

	// A zero factor gives a zero product once it has crossed the pipeline.
	assert_zero_factor: assert property (
		@(posedge clk) disable iff (!arst_n)
		(operands_q.a == '0 || operands_q.b == '0) |-> ##(`MULT_LATENCY) product == '0
	) else $error("nonzero product for a zero operand");

	assert_no_unknown: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(product))
		else $error("product has unknown bits after reset");

endmodule

bind wallace_mult wallace_mult_properties u_wallace_mult_properties (
	.clk        (clk),
	.arst_n     (arst_n),
	.operands_q (operands_q),
	.product    (product)
);

// ==== bench/wallace_mult_tb.sv ====
`timescale 1ns/100ps

`include "wallace_mult_config.svh"

// Testbench for the pipelined Wallace tree multiplier.
module wallace_mult_tb;

	import wallace_mult_pkg::*;

	localparam int PERIOD       = 10;
	localparam int DRIVE_DELAY  = 1;  // Inputs change this long after the rising edge.
	localparam int RESET_CYCLES = 4;
	localparam int RANDOM_COUNT = 200;
	localparam int RESET_PULSE  = 3;  // Cycles of the reset applied mid-stream.
	localparam int TAIL_COUNT   = 20; // Random pairs after the mid-stream reset.
	localparam int MARGIN       = 50; // Spare cycles for the watchdog.

	// One table entry.
	typedef struct packed {
		operand_t   a;
		operand_t   b;
		product_t   expected;
		logic [7:0] hold; // Cycles the pair stays on the inputs.
	} vector_t;

	localparam int VECTOR_COUNT = 20;

	localparam vector_t VECTORS [0:VECTOR_COUNT-1] = '{
		'{16'h0000, 16'h0000, 32'h0000_0000, 8'd1},
		'{16'h0001, 16'hFFFF, 32'h0000_FFFF, 8'd1},
		'{16'hFFFF, 16'hFFFF, 32'hFFFE_0001, 8'd1}, // Largest product.
		'{16'h8000, 16'h8000, 32'h4000_0000, 8'd1},
		'{16'hAAAA, 16'h5555, 32'h38E3_1C72, 8'd1},
		'{16'hFFFF, 16'h0001, 32'h0000_FFFF, 8'd1},
		'{16'hFFFF, 16'h0000, 32'h0000_0000, 8'd1},
		'{16'h7FFF, 16'h7FFF, 32'h3FFF_0001, 8'd1},
		'{16'h0001, 16'h0001, 32'h0000_0001, 8'd1}, // Walking ones.
		'{16'h0002, 16'h0004, 32'h0000_0008, 8'd1},
		'{16'h0010, 16'h0100, 32'h0000_1000, 8'd1},
		'{16'h0400, 16'h0020, 32'h0000_8000, 8'd1},
		'{16'h1000, 16'h8000, 32'h0800_0000, 8'd1},
		'{16'h8000, 16'h0002, 32'h0001_0000, 8'd1},
		'{16'h1234, 16'h5678, 32'h0626_0060, 8'd1},
		'{16'h00FF, 16'h00FF, 32'h0000_FE01, 8'd1},
		'{16'hDEAD, 16'hBEEF, 32'hA614_4983, 8'd1},
		'{16'h00C3, 16'h0A5F, 32'h0007_E65D, 8'd5}, // Held operands.
		'{16'hFFFF, 16'hFFFF, 32'hFFFE_0001, 8'd3},
		'{16'h0000, 16'h0000, 32'h0000_0000, 8'd1}
	};

	logic        clk;
	logic        arst_n;
	operands_t   operands;
	product_t    product;
	product_t    expected_in;    // Expected product of the pair on the inputs.
	product_t    expected_now;   // What product should read after the last edge.
	product_t    expected_q [$]; // Products still inside the pipeline.
	logic [31:0] rng_state;
	int          check_count;

	wallace_mult u_wallace_mult (
		.clk      (clk),
		.arst_n   (arst_n),
		.operands (operands),
		.product  (product)
	);

	// Xorshift32 step.
	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Clock cycles spent on the corner table.
	function automatic int table_cycles();
		int total;
		total = 0;
		for (int i = 0; i < VECTOR_COUNT; i++) begin
			total += int'(VECTORS[i].hold);
		end
		return total;
	endfunction

	task automatic compare(input product_t actual, input product_t expected, input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s, product %h, expected %h",
				$time, what, actual, expected);
			$display("Verification failed");
			$fatal(1, "Product mismatch.");
		end
	endtask

	// Pipeline contents after a reset.
	task automatic flush_expected();
		expected_q.delete();
		repeat (`MULT_LATENCY) expected_q.push_back('0);
	endtask

	task automatic drive_pair(input operand_t a, input operand_t b, input product_t expected);
		@(posedge clk);
		#DRIVE_DELAY;
		operands.a  = a;
		operands.b  = b;
		expected_in = expected;
	endtask

	task automatic drive_random();
		operand_t a;
		operand_t b;
		rng_state = next_random(rng_state);
		a = rng_state[31:16];
		b = rng_state[15:0];
		drive_pair(a, b, product_t'(a) * product_t'(b));
	endtask

	// Reset while products are in flight.
	task automatic pulse_reset(input int cycles);
		@(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b0;
		repeat (cycles) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;
	endtask

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Model of the pipeline and output check.
	initial begin
		check_count = 0;
		flush_expected();
		forever begin
			@(posedge clk);
			if (!arst_n) begin
				flush_expected();
				expected_now = '0;
			end else begin
				expected_now = expected_q.pop_front();
				expected_q.push_back(expected_in); // Pair sampled at this edge.
			end
			@(negedge clk);
			if (!arst_n) begin
				flush_expected(); // Reset may have arrived after the edge.
				expected_now = '0;
			end
			check_count++;
			compare(product, expected_now, $sformatf("output check %0d", check_count));
		end
	end

	initial begin
		int limit_cycles;
		limit_cycles = RESET_CYCLES + table_cycles() + RANDOM_COUNT + RESET_PULSE + 1
			+ TAIL_COUNT + `MULT_LATENCY + MARGIN;
		#(limit_cycles * PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles.", limit_cycles);
		$display("Verification failed");
		$fatal(1, "Watchdog expired.");
	end

	initial begin
		rng_state   = 32'h50ca_d7ac;
		arst_n      = 1'b1; // Falls at 1 ns to give the flops a real edge.
		operands    = '0;
		expected_in = '0;
		#DRIVE_DELAY;
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;

		for (int i = 0; i < VECTOR_COUNT; i++) begin
			repeat (VECTORS[i].hold) begin
				drive_pair(VECTORS[i].a, VECTORS[i].b, VECTORS[i].expected);
			end
		end

		repeat (RANDOM_COUNT) drive_random(); // One new pair every cycle.
		pulse_reset(RESET_PULSE);
		repeat (TAIL_COUNT) drive_random();

		// Drain the pipeline.
		repeat (`MULT_LATENCY + 1) @(posedge clk);
		@(negedge clk);
		#DRIVE_DELAY;
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/wallace_mult_pkg.sv
hdl/wallace_tree.sv
hdl/carry_ripple_adder.sv
hdl/wallace_mult.sv
bench/wallace_mult_properties.sv
bench/wallace_mult_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module wallace_mult_tb -o sim_wallace_mult \
	|| { echo "Build failed"; exit 1; }

./obj_dir/sim_wallace_mult > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Verification passed" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation completed without errors"
